// File: hw/issue_settings.svh
// Global sizing for the issue slice
// Data width, register file size, issue queue depth and bundle width
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Integer datapath width
`define ISSUE_XLEN 64

// Architectural registers and the index width that addresses them
`define ISSUE_NREGS 16
`define ISSUE_RIDX_W $clog2(`ISSUE_NREGS)

// Issue queue entries, also the allocator's starting credit count
`define ISSUE_DEPTH 4

`define ISSUE_SLOTS 2 // Operations per decoded bundle

`endif

// File: hw/issue_pkg.sv
// Shared types of the issue slice
// ALU operation codes and the issue queue entry
`include "issue_settings.svh"

package issue_pkg;

  // ******************************
  // Operation codes
  // ******************************
  typedef enum logic [1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_and = 2'd2,
    alu_xor = 2'd3
  } alu_op_e;

  // One decoded operation as it sits in the issue queue
  typedef struct packed {
    alu_op_e                  op;
    logic [`ISSUE_RIDX_W-1:0] rd;
    logic [`ISSUE_RIDX_W-1:0] ra;
    logic [`ISSUE_RIDX_W-1:0] rb;
    logic                     imm_en; // Immediate takes the place of rb
    logic [`ISSUE_XLEN-1:0]   imm;
    logic                     fwd_a;  // ra is the rd of the previous operation
    logic                     fwd_b;
  } issue_entry_t;

endpackage

// File: hw/bypass_regfile.sv
// Integer register file
// Two read ports, one write port, write data forwarded to same-cycle reads
`timescale 1ns/1ps
`include "issue_settings.svh"

module bypass_regfile (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`ISSUE_RIDX_W-1:0] ra_addr,
  input  logic [`ISSUE_RIDX_W-1:0] rb_addr,
  input  logic                     wr_en,
  input  logic [`ISSUE_RIDX_W-1:0] wr_addr,
  input  logic [`ISSUE_XLEN-1:0]   wr_data,
  output logic [`ISSUE_XLEN-1:0]   ra_data,
  output logic [`ISSUE_XLEN-1:0]   rb_data
);

  logic [`ISSUE_XLEN-1:0] regs [`ISSUE_NREGS];
  logic                   hit_a;
  logic                   hit_b;

  // ******************************
  // Storage
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ISSUE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // A reader two operations behind its producer lands here in the write cycle
  assign hit_a = wr_en && (wr_addr == ra_addr);
  assign hit_b = wr_en && (wr_addr == rb_addr);

  assign ra_data = hit_a ? wr_data : regs[ra_addr];
  assign rb_data = hit_b ? wr_data : regs[rb_addr];

endmodule

// File: hw/slot_allocator.sv
// Slot allocator
// Holds one bundle, emits its valid slots in program order, tags forwarding
// hints from the last pushed destination and keeps the queue credit count
`timescale 1ns/1ps
`include "issue_settings.svh"

module slot_allocator (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     bundle_valid,
  output logic                     bundle_ready,
  input  logic                     s0_valid,
  input  issue_pkg::alu_op_e       s0_op,
  input  logic [`ISSUE_RIDX_W-1:0] s0_rd,
  input  logic [`ISSUE_RIDX_W-1:0] s0_ra,
  input  logic [`ISSUE_RIDX_W-1:0] s0_rb,
  input  logic                     s0_imm_en,
  input  logic [`ISSUE_XLEN-1:0]   s0_imm,
  input  logic                     s1_valid,
  input  issue_pkg::alu_op_e       s1_op,
  input  logic [`ISSUE_RIDX_W-1:0] s1_rd,
  input  logic [`ISSUE_RIDX_W-1:0] s1_ra,
  input  logic [`ISSUE_RIDX_W-1:0] s1_rb,
  input  logic                     s1_imm_en,
  input  logic [`ISSUE_XLEN-1:0]   s1_imm,
  input  logic                     credit_return,
  output logic                     push,
  output issue_pkg::issue_entry_t  push_entry
);

  localparam int CRED_W = $clog2(`ISSUE_DEPTH + 1);

  logic [`ISSUE_SLOTS-1:0]  hold_valid; // Slots of the held bundle still to emit
  issue_pkg::issue_entry_t  hold_entry [`ISSUE_SLOTS];
  logic [`ISSUE_RIDX_W-1:0] last_rd;
  logic                     last_valid;
  logic [CRED_W-1:0]        credits;
  logic                     accept;
  logic                     sel;
  issue_pkg::issue_entry_t  cur;

  assign bundle_ready = ~|hold_valid;
  assign accept = bundle_valid && bundle_ready;
  assign sel = ~hold_valid[0]; // Slot0 goes first whenever it is still pending
  assign push = (|hold_valid) && (credits != '0);

  // Hints compare against the destination of the operation pushed just before
  always_comb begin
    cur = hold_entry[sel];
    cur.fwd_a = last_valid && (cur.ra == last_rd);
    cur.fwd_b = last_valid && !cur.imm_en && (cur.rb == last_rd);
  end

  assign push_entry = cur;

  // ******************************
  // Bundle holding register
  // ******************************
  always_ff @(posedge clk) begin
    if (accept) begin
      hold_entry[0] <= '{op: s0_op, rd: s0_rd, ra: s0_ra, rb: s0_rb, imm_en: s0_imm_en,
                         imm: s0_imm, fwd_a: 1'b0, fwd_b: 1'b0};
      hold_entry[1] <= '{op: s1_op, rd: s1_rd, ra: s1_ra, rb: s1_rb, imm_en: s1_imm_en,
                         imm: s1_imm, fwd_a: 1'b0, fwd_b: 1'b0};
    end
    if (push) begin
      last_rd <= cur.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_valid <= '0;
      last_valid <= 1'b0;
      credits <= CRED_W'(`ISSUE_DEPTH);
    end else begin
      if (accept) begin
        hold_valid <= {s1_valid, s0_valid};
      end else if (push) begin
        hold_valid[sel] <= 1'b0;
      end
      if (push) begin
        last_valid <= 1'b1;
      end
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // Spent and returned in the same cycle
      endcase
    end
  end

  // More credits than queue entries means the queue returned one twice
  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= CRED_W'(`ISSUE_DEPTH));

  // A credit comes back only for an entry that was pushed and is still owed
  a_credit_owed: assert property (@(posedge clk) disable iff (rst)
    credit_return |-> credits != CRED_W'(`ISSUE_DEPTH));

endmodule

// File: hw/issue_fifo.sv
// Issue queue
// Circular buffer with occupancy count, one credit returned per pop
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  issue_pkg::issue_entry_t push_entry,
  input  logic                    pop,
  output logic                    pop_valid,
  output issue_pkg::issue_entry_t pop_entry,
  output logic                    credit_return
);

  localparam int PTR_W = $clog2(`ISSUE_DEPTH);
  localparam int CNT_W = $clog2(`ISSUE_DEPTH + 1);

  issue_pkg::issue_entry_t mem [`ISSUE_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;

  // Wraps at the last entry so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(`ISSUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop_valid = (count != '0);
  assign pop_entry = mem[rd_ptr]; // Head is shown as soon as it is written

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  // ******************************
  // Pointers, count and credits
  // ******************************
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pop; // Freed entry goes back to the allocator next cycle
    end
  end

  // The allocator only pushes against a credit, so a full queue never sees one
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> count != CNT_W'(`ISSUE_DEPTH));

endmodule

// File: hw/alu_exec.sv
// Execute unit
// Operand read stage, ALU stage with previous-result forwarding,
// write-back stage feeding the register file and the outputs
`timescale 1ns/1ps
`include "issue_settings.svh"

module alu_exec (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  input  logic                     pop_valid,
  input  issue_pkg::issue_entry_t  pop_entry,
  output logic                     pop,
  output logic                     wb_valid,
  output logic [`ISSUE_RIDX_W-1:0] wb_rd,
  output logic [`ISSUE_XLEN-1:0]   wb_data
);

  logic [`ISSUE_XLEN-1:0]   rf_a;
  logic [`ISSUE_XLEN-1:0]   rf_b;
  logic                     op_valid;
  issue_pkg::alu_op_e       op_op;
  logic [`ISSUE_RIDX_W-1:0] op_rd;
  logic                     op_fwd_a;
  logic                     op_fwd_b;
  logic [`ISSUE_XLEN-1:0]   op_a;
  logic [`ISSUE_XLEN-1:0]   op_b;
  logic                     ex_valid;
  logic [`ISSUE_RIDX_W-1:0] ex_rd;
  logic [`ISSUE_XLEN-1:0]   ex_result;
  logic [`ISSUE_XLEN-1:0]   alu_a;
  logic [`ISSUE_XLEN-1:0]   alu_b;
  logic [`ISSUE_XLEN-1:0]   alu_out;
  logic                     rf_wr_en;

  assign pop = pop_valid && !stall;
  assign rf_wr_en = ex_valid && !stall; // One write per retiring operation

  bypass_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .ra_addr (pop_entry.ra),
    .rb_addr (pop_entry.rb),
    .wr_en   (rf_wr_en),
    .wr_addr (ex_rd),
    .wr_data (ex_result),
    .ra_data (rf_a),
    .rb_data (rf_b)
  );

  // ******************************
  // Operand stage
  // ******************************
  always_ff @(posedge clk) begin
    if (pop) begin
      op_op <= pop_entry.op;
      op_rd <= pop_entry.rd;
      op_fwd_a <= pop_entry.fwd_a;
      op_fwd_b <= pop_entry.fwd_b;
      op_a <= rf_a;
      op_b <= pop_entry.imm_en ? pop_entry.imm : rf_b;
    end
  end

  // ******************************
  // ALU stage
  // ******************************
  // ex_result only reloads on a real operation, so it always holds the last result
  assign alu_a = op_fwd_a ? ex_result : op_a;
  assign alu_b = op_fwd_b ? ex_result : op_b;

  always_comb begin
    case (op_op)
      issue_pkg::alu_add: alu_out = alu_a + alu_b;
      issue_pkg::alu_sub: alu_out = alu_a - alu_b;
      issue_pkg::alu_and: alu_out = alu_a & alu_b;
      default:            alu_out = alu_a ^ alu_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!stall && op_valid) begin
      ex_rd <= op_rd;
      ex_result <= alu_out;
    end
    if (rf_wr_en) begin
      wb_rd <= ex_rd;
      wb_data <= ex_result;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_valid <= 1'b0;
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (!stall) begin
        op_valid <= pop;
        ex_valid <= op_valid;
      end
      wb_valid <= rf_wr_en; // Pulses once per write, never stretched by stall
    end
  end

  a_wb_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wb_valid));

endmodule

// File: hw/issue_top.sv
// Issue slice top level
// Slot allocator, issue queue and execute unit
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  input  logic                     bundle_valid,
  output logic                     bundle_ready,
  input  logic                     s0_valid,
  input  issue_pkg::alu_op_e       s0_op,
  input  logic [`ISSUE_RIDX_W-1:0] s0_rd,
  input  logic [`ISSUE_RIDX_W-1:0] s0_ra,
  input  logic [`ISSUE_RIDX_W-1:0] s0_rb,
  input  logic                     s0_imm_en,
  input  logic [`ISSUE_XLEN-1:0]   s0_imm,
  input  logic                     s1_valid,
  input  issue_pkg::alu_op_e       s1_op,
  input  logic [`ISSUE_RIDX_W-1:0] s1_rd,
  input  logic [`ISSUE_RIDX_W-1:0] s1_ra,
  input  logic [`ISSUE_RIDX_W-1:0] s1_rb,
  input  logic                     s1_imm_en,
  input  logic [`ISSUE_XLEN-1:0]   s1_imm,
  output logic                     wb_valid,
  output logic [`ISSUE_RIDX_W-1:0] wb_rd,
  output logic [`ISSUE_XLEN-1:0]   wb_data
);

  logic                    push;
  issue_pkg::issue_entry_t push_entry;
  logic                    credit_return;
  logic                    pop_valid;
  issue_pkg::issue_entry_t pop_entry;
  logic                    pop;

  slot_allocator u_alloc (
    .clk           (clk),
    .rst           (rst),
    .bundle_valid  (bundle_valid),
    .bundle_ready  (bundle_ready),
    .s0_valid      (s0_valid),
    .s0_op         (s0_op),
    .s0_rd         (s0_rd),
    .s0_ra         (s0_ra),
    .s0_rb         (s0_rb),
    .s0_imm_en     (s0_imm_en),
    .s0_imm        (s0_imm),
    .s1_valid      (s1_valid),
    .s1_op         (s1_op),
    .s1_rd         (s1_rd),
    .s1_ra         (s1_ra),
    .s1_rb         (s1_rb),
    .s1_imm_en     (s1_imm_en),
    .s1_imm        (s1_imm),
    .credit_return (credit_return),
    .push          (push),
    .push_entry    (push_entry)
  );

  issue_fifo u_queue (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_entry    (push_entry),
    .pop           (pop),
    .pop_valid     (pop_valid),
    .pop_entry     (pop_entry),
    .credit_return (credit_return)
  );

  alu_exec u_exec (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .pop_valid (pop_valid),
    .pop_entry (pop_entry),
    .pop       (pop),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

endmodule

// File: bench/issue_tb.sv
// Testbench for the issue slice
// Vector reader, in-order reference model, stall generator, write-back
// monitor with latency check, compare tasks and watchdog
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_tb;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic stall = 1'b0;
  logic bundle_valid = 1'b0;
  logic bundle_ready;
  logic s_valid [2] = '{1'b0, 1'b0};
  issue_pkg::alu_op_e s_op [2] = '{issue_pkg::alu_add, issue_pkg::alu_add};
  logic [`ISSUE_RIDX_W-1:0] s_rd [2] = '{'0, '0};
  logic [`ISSUE_RIDX_W-1:0] s_ra [2] = '{'0, '0};
  logic [`ISSUE_RIDX_W-1:0] s_rb [2] = '{'0, '0};
  logic s_imm_en [2] = '{1'b0, 1'b0};
  logic [`ISSUE_XLEN-1:0] s_imm [2] = '{'0, '0};
  logic wb_valid;
  logic [`ISSUE_RIDX_W-1:0] wb_rd;
  logic [`ISSUE_XLEN-1:0] wb_data;

  string test_name = "reset";
  logic stall_mode = 1'b0;
  int cyc = 0;
  int nlines = 0;
  int max_wait = 0;
  logic [`ISSUE_XLEN-1:0] model_regs [`ISSUE_NREGS];
  logic [`ISSUE_RIDX_W-1:0] pred_rd [$];
  logic [`ISSUE_XLEN-1:0] pred_data [$];
  logic [`ISSUE_RIDX_W-1:0] exp_rd [$];
  logic [`ISSUE_XLEN-1:0] exp_data [$];
  int pop_cyc [$];

  always #4 clk = ~clk;

  issue_top dut (
    .clk(clk), .rst(rst), .stall(stall),
    .bundle_valid(bundle_valid), .bundle_ready(bundle_ready),
    .s0_valid(s_valid[0]), .s0_op(s_op[0]), .s0_rd(s_rd[0]), .s0_ra(s_ra[0]),
    .s0_rb(s_rb[0]), .s0_imm_en(s_imm_en[0]), .s0_imm(s_imm[0]),
    .s1_valid(s_valid[1]), .s1_op(s_op[1]), .s1_rd(s_rd[1]), .s1_ra(s_ra[1]),
    .s1_rb(s_rb[1]), .s1_imm_en(s_imm_en[1]), .s1_imm(s_imm[1]),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_data(input string name, input logic [`ISSUE_XLEN-1:0] exp,
                            input logic [`ISSUE_XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_reg(input string name, input logic [`ISSUE_RIDX_W-1:0] exp,
                           input logic [`ISSUE_RIDX_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s expected r%0d actual r%0d", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic logic [63:0] xorshift(input logic [63:0] x);
    logic [63:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    return y ^ (y << 17);
  endfunction

  // In-order execution of one slot, following the ALU rules
  task automatic model_slot(input logic [1:0] op, input logic [`ISSUE_RIDX_W-1:0] rd,
                            input logic [`ISSUE_RIDX_W-1:0] ra,
                            input logic [`ISSUE_RIDX_W-1:0] rb,
                            input logic imm_en, input logic [`ISSUE_XLEN-1:0] imm);
    logic [`ISSUE_XLEN-1:0] a;
    logic [`ISSUE_XLEN-1:0] b;
    logic [`ISSUE_XLEN-1:0] r;
    a = model_regs[ra];
    b = imm_en ? imm : model_regs[rb];
    case (op)
      2'd0: r = a + b;
      2'd1: r = a - b;
      2'd2: r = a & b;
      default: r = a ^ b;
    endcase
    model_regs[rd] = r;
    pred_rd.push_back(rd);
    pred_data.push_back(r);
  endtask

  // Long stall runs that open with a high one so the queue fills up
  always @(posedge clk) begin : stall_gen
    logic [63:0] rng;
    int run_left;
    logic prev_mode;
    #1;
    if (cyc <= 1) begin
      rng = 64'd81;
      run_left = 0;
      prev_mode = 1'b0;
    end
    if (!stall_mode) begin
      stall <= 1'b0;
    end else if (!prev_mode) begin
      stall <= 1'b1;
      run_left = 12;
    end else if (run_left == 0) begin
      rng = xorshift(rng);
      stall <= rng[0];
      run_left = 4 + int'(rng[11:8]);
    end else begin
      run_left = run_left - 1;
    end
    prev_mode = stall_mode;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Outputs are sampled at the falling edge where they are stable
  always @(negedge clk) begin
    if (!rst && dut.pop) begin
      pop_cyc.push_back(cyc);
    end
    if (!rst && wb_valid) begin
      if (exp_rd.size() == 0) begin
        $display("Write-back to r%0d arrived with none expected in %s", wb_rd, test_name);
        $display("test failed");
        $fatal(1);
      end
      check_reg({test_name, " wb_rd"}, exp_rd.pop_front(), wb_rd);
      check_data({test_name, " wb_data"}, exp_data.pop_front(), wb_data);
      if (!stall_mode) begin
        check_flag({test_name, " pop to wb is 3 edges"}, 1'b1, (cyc - pop_cyc[0]) == 3);
      end
      void'(pop_cyc.pop_front());
    end
  end

  task automatic drive_bundle(input logic [63:0] f [14]);
    logic accepted;
    int waited;
    for (int s = 0; s < 2; s++) begin
      s_valid[s] = f[s*7][0];
      s_op[s] = issue_pkg::alu_op_e'(f[s*7+1][1:0]);
      s_rd[s] = f[s*7+2][`ISSUE_RIDX_W-1:0];
      s_ra[s] = f[s*7+3][`ISSUE_RIDX_W-1:0];
      s_rb[s] = f[s*7+4][`ISSUE_RIDX_W-1:0];
      s_imm_en[s] = f[s*7+5][0];
      s_imm[s] = f[s*7+6];
      if (f[s*7][0]) begin
        model_slot(f[s*7+1][1:0], s_rd[s], s_ra[s], s_rb[s], s_imm_en[s], s_imm[s]);
      end
    end
    bundle_valid = 1'b1;
    waited = 0;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = bundle_ready;
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited > max_wait) max_wait = waited;
    bundle_valid = 1'b0;
  endtask

  task automatic drain;
    while (exp_rd.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : watchdog
    wait (nlines > 0);
    repeat (nlines * 40) @(posedge clk);
    $display("Simulation hung: write-backs still missing in %s", test_name);
    $display("test failed");
    $fatal(1);
  end

  initial begin : main
    int fd;
    int code;
    int mode;
    logic [8*256-1:0] line_raw;
    logic [8*8-1:0] tag;
    logic [8*32-1:0] name_raw;
    logic [63:0] f [14];
    for (int i = 0; i < `ISSUE_NREGS; i++) model_regs[i] = '0;
    fd = $fopen("bench/issue_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file bench/issue_vectors.txt");
      $display("test failed");
      $fatal(1);
    end
    while ($fgets(line_raw, fd)) begin
      if ($sscanf(line_raw, "%s", tag) == 1 && tag != "#") nlines++;
    end
    $fclose(fd);
    fd = $fopen("bench/issue_vectors.txt", "r");
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_flag("reset wb_valid", 1'b0, wb_valid);
    check_flag("reset bundle_ready", 1'b1, bundle_ready);
    while ($fgets(line_raw, fd)) begin
      code = $sscanf(line_raw, "%s", tag);
      if (code < 1 || tag == "#") continue;
      if (tag == "T") begin
        // A stall run must have kept a bundle waiting on credits
        if (stall_mode) begin
          check_flag({test_name, " bundle_ready held low"}, 1'b1, max_wait >= 4);
        end
        drain();
        code = $sscanf(line_raw, "%s %s %d", tag, name_raw, mode);
        test_name = $sformatf("%0s", name_raw);
        stall_mode = (mode != 0);
        max_wait = 0;
      end else if (tag == "B") begin
        code = $sscanf(line_raw, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                       f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        drive_bundle(f);
      end else if (tag == "W") begin
        code = $sscanf(line_raw, "%s %h %h", tag, f[0], f[1]);
        if (pred_rd.size() == 0) begin
          $display("Vector file lists a write-back with no operation in %s", test_name);
          $display("test failed");
          $fatal(1);
        end
        check_reg({test_name, " vector file rd"}, pred_rd.pop_front(), f[0][3:0]);
        check_data({test_name, " vector file data"}, pred_data.pop_front(), f[1]);
        exp_rd.push_back(f[0][3:0]);
        exp_data.push_back(f[1]);
      end
    end
    $fclose(fd);
    if (stall_mode) begin
      check_flag({test_name, " bundle_ready held low"}, 1'b1, max_wait >= 4);
    end
    drain();
    stall_mode = 1'b0;
    repeat (6) @(posedge clk);
    if (pred_rd.size() != 0 || exp_rd.size() != 0 || pop_cyc.size() != 0) begin
      $display("Operations left over after the last vector");
      $display("test failed");
      $fatal(1);
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: issue_top.f
+incdir+hw
hw/issue_pkg.sv
hw/bypass_regfile.sv
hw/slot_allocator.sv
hw/issue_fifo.sv
hw/alu_exec.sv
hw/issue_top.sv
bench/issue_tb.sv

// File: Makefile
# Verilator flow for the issue slice

TOOL     = verilator
FLAGS    = --binary --timing --assert -Ihw
TOP      = issue_tb
RTL_TOP  = issue_top
FILELIST = issue_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Ihw --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) hw/*.sv hw/*.svh bench/*.sv
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/issue_vectors.txt
# T name stall_mode | B v op rd ra rb imm_en imm (slot0) v op rd ra rb imm_en imm (slot1)
# W rd data is one expected write-back in program order, all B and W fields hex
T reset_zero 0
B 1 0 1 0 0 0 0 1 0 2 0 0 0 0
W 1 0
W 2 0
T independent 0
B 1 0 3 0 0 1 5 1 0 4 0 0 1 FFFFFFFFFFFFFFFF
W 3 5
W 4 FFFFFFFFFFFFFFFF
B 1 1 5 0 3 0 0 1 2 6 4 0 1 F0
W 5 FFFFFFFFFFFFFFFB
W 6 F0
B 1 3 7 6 0 1 F 1 0 8 4 4 0 0
W 7 FF
W 8 FFFFFFFFFFFFFFFE
T dependent 0
B 1 0 9 3 3 0 0 1 0 9 9 9 0 0
W 9 A
W 9 14
B 1 1 A 9 0 1 1 1 3 B 9 A 0 0
W A 13
W B 7
T partial 0
B 0 0 0 0 0 0 0 1 0 C B 0 1 100
W C 107
B 0 0 0 0 0 0 0 0 0 0 0 0 0 0
B 1 2 D C 5 0 0 0 0 0 0 0 0 0
W D 103
T stall_burst 1
B 1 0 1 3 3 0 0 1 0 2 1 1 0 0
W 1 A
W 2 14
B 1 0 3 2 1 0 0 1 1 4 3 1 0 0
W 3 1E
W 4 14
B 1 3 5 4 2 0 0 1 0 6 5 0 1 9
W 5 0
W 6 9
B 1 0 7 6 6 0 0 1 2 8 7 F 0 0
W 7 12
W 8 0
